// File: common/vec_pkg.sv
/* Shared sizes, opcode enum, identifier and request types for the vector
   issue subsystem, plus opcode helper functions */
package vec_pkg;

  localparam int unsigned NrVInsn  = 8;
  localparam int unsigned NrVRegs  = 8;
  localparam int unsigned VLen     = 32;
  localparam int unsigned MemWords = 64;
  localparam int unsigned NrPEs    = 3;

  // Processing element slots on the broadcast bus
  localparam int unsigned PeAlu   = 0;
  localparam int unsigned PeLoad  = 1;
  localparam int unsigned PeStore = 2;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [VLen-1:0]            vdata_t;
  typedef logic [7:0]                 addr_t;
  typedef logic [NrVInsn-1:0]         vid_mask_t;

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VXOR,
    VLE,
    VSE
  } vec_op_e;

  typedef struct packed {
    vid_t      id;
    vec_op_e   op;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    addr_t     addr;
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vd;
  } pe_req_t;

  // Last reader or writer of one vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } access_t;

  function automatic logic is_mem(vec_op_e op);
    return op inside {VLE, VSE};
  endfunction

  function automatic int unsigned target_pe(vec_op_e op);
    case (op)
      VLE:     return PeLoad;
      VSE:     return PeStore;
      default: return PeAlu;
    endcase
  endfunction

endpackage

// File: common/pe_req_if.sv
/* Broadcast from the sequencer to the processing elements */
interface pe_req_if import vec_pkg::*; ();

  pe_req_t          req;
  logic             req_valid;
  vid_mask_t        running;
  // One bit per processing element
  logic [NrPEs-1:0] req_ready;
  logic [NrPEs-1:0] done;

  modport sequencer (
    output req, req_valid, running,
    input  req_ready, done
  );

  modport unit (
    input  req, req_valid, running,
    output req_ready, done
  );

endinterface

// File: common/mem_port_if.sv
/* One memory requester toward the bus arbiter */
interface mem_port_if import vec_pkg::*; ();

  logic   req;
  logic   we;
  addr_t  addr;
  vdata_t wdata;
  logic   gnt;
  // Valid in the gnt cycle
  vdata_t rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

// File: sequencer/vec_sequencer.sv
/* Vector instruction sequencer: identifier pool, register access lists,
   hazard bitmaps, issue to the units and memory commit FSM */
module vec_sequencer import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  vec_op_e     req_op_i,
  input  vreg_t       req_vd_i,
  input  vreg_t       req_vs1_i,
  input  vreg_t       req_vs2_i,
  input  addr_t       req_addr_i,
  output logic        resp_valid_o,
  output logic        resp_error_o,
  output logic        idle_o,
  pe_req_if.sequencer pe,
  input  logic        ld_ack_i,
  input  logic        ld_err_i,
  input  logic        st_ack_i,
  input  logic        st_err_i
);

  typedef enum logic {IDLE, WAIT} state_e;

  state_e                        state_q, state_d;
  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_q, pe_running_d;
  vid_mask_t                     running, running_left, done_ids;
  logic                          done_clash;
  vid_t                          next_id;
  logic                          full;
  access_t [NrVRegs-1:0]         read_list_q, read_list_d;
  access_t [NrVRegs-1:0]         write_list_q, write_list_d;
  pe_req_t                       req_q, req_d;
  logic                          req_valid_q, accept;
  logic                          use_vs1, use_vs2, use_vd;
  logic                          ack, resp_valid_q, resp_error_q;

  //////////////////////////////
  // Running instructions
  //////////////////////////////

  always_comb begin
    running    = '0;
    done_ids   = '0;
    done_clash = 1'b0;
    for (int p = 0; p < NrPEs; p++) begin
      running |= pe_running_q[p];
      if (pe.done[p]) begin
        done_clash |= |(done_ids & pe_running_q[p]);
        done_ids   |= pe_running_q[p];
      end
    end
    // Still running once this cycle's completions are retired
    running_left = running & ~done_ids;
  end

  // Lowest free identifier
  always_comb begin
    next_id = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running[i]) next_id = vid_t'(i);
    end
  end

  assign full   = &running;
  assign idle_o = ~|running;
  assign ack    = ld_ack_i || st_ack_i;

  //////////////////////////////
  // Hazards and issue
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    for (int p = 0; p < NrPEs; p++) pe_running_d[p] = pe_running_q[p] & ~done_ids;

    for (int v = 0; v < NrVRegs; v++) begin
      read_list_d[v].valid  &= running_left[read_list_q[v].vid];
      write_list_d[v].valid &= running_left[write_list_q[v].vid];
    end

    use_vs1 = (req_op_i != VLE);
    use_vs2 = !is_mem(req_op_i);
    use_vd  = (req_op_i != VSE);

    req_d = '{id: next_id, op: req_op_i, vd: req_vd_i, vs1: req_vs1_i, vs2: req_vs2_i,
              addr: req_addr_i, default: '0};

    // RAW on the sources
    if (use_vs1) begin
      req_d.hazard_vs1[write_list_d[req_vs1_i].vid] |= write_list_d[req_vs1_i].valid;
    end
    if (use_vs2) begin
      req_d.hazard_vs2[write_list_d[req_vs2_i].vid] |= write_list_d[req_vs2_i].valid;
    end
    // WAR and WAW on the destination
    if (use_vd) begin
      req_d.hazard_vd[read_list_d[req_vd_i].vid]  |= read_list_d[req_vd_i].valid;
      req_d.hazard_vd[write_list_d[req_vd_i].vid] |= write_list_d[req_vd_i].valid;
    end

    // Nothing new while a broadcast is in flight or a unit is busy
    req_ready_o = (state_q == IDLE) && !req_valid_q && (&pe.req_ready) && !full;
    accept      = req_valid_i && req_ready_o;

    if (accept) begin
      pe_running_d[target_pe(req_op_i)][next_id] = 1'b1;
      if (use_vd) write_list_d[req_vd_i] = '{vid: next_id, valid: 1'b1};
      if (use_vs1) read_list_d[req_vs1_i] = '{vid: next_id, valid: 1'b1};
      if (use_vs2) read_list_d[req_vs2_i] = '{vid: next_id, valid: 1'b1};
      // Memory instructions wait for the address check
      if (is_mem(req_op_i)) state_d = WAIT;
    end

    if (state_q == WAIT && ack) state_d = IDLE;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      pe_running_q <= '0;
      read_list_q  <= '0;
      write_list_q <= '0;
      req_valid_q  <= 1'b0;
      resp_valid_q <= 1'b0;
      resp_error_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      pe_running_q <= pe_running_d;
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
      req_valid_q  <= accept;
      resp_valid_q <= (state_q == WAIT) && ack;
      if (ack) resp_error_q <= ld_ack_i ? ld_err_i : st_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_d;
  end

  assign pe.req       = req_q;
  assign pe.req_valid = req_valid_q;
  assign pe.running   = running;

  assign resp_valid_o = resp_valid_q;
  assign resp_error_o = resp_error_q;

  // Units must still be free when the broadcast lands
  assert property (@(posedge clk_i) disable iff (!rst_ni) pe.req_valid |-> &pe.req_ready)
    else $error("broadcast while a unit is busy");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !done_clash)
    else $error("two units completed the same instruction");

endmodule

// File: logic/vec_alu_unit.sv
/* Element-wise ALU on four 8-bit elements: hazard wait, compute, write back */
module vec_alu_unit import vec_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  pe_req_if.unit pe,
  output vreg_t  rd_a_addr_o,
  output vreg_t  rd_b_addr_o,
  input  vdata_t rd_a_data_i,
  input  vdata_t rd_b_data_i,
  output logic   wr_req_o,
  output vreg_t  wr_addr_o,
  output vdata_t wr_data_o,
  input  logic   wr_gnt_i
);

  logic      busy_q, wr_req_q, take, start;
  vec_op_e   op_q;
  vreg_t     vd_q, vs1_q, vs2_q;
  vid_mask_t hz_q;
  vdata_t    res_d, res_q;

  assign take  = pe.req_valid && (target_pe(pe.req.op) == PeAlu);
  // Operands are final once no older instruction is left in the hazard set
  assign start = busy_q && !wr_req_q && !(|(hz_q & pe.running));

  always_comb begin
    res_d = '0;
    for (int e = 0; e < VLen / 8; e++) begin
      case (op_q)
        VSUB:    res_d[8*e +: 8] = rd_a_data_i[8*e +: 8] - rd_b_data_i[8*e +: 8];
        VAND:    res_d[8*e +: 8] = rd_a_data_i[8*e +: 8] & rd_b_data_i[8*e +: 8];
        VXOR:    res_d[8*e +: 8] = rd_a_data_i[8*e +: 8] ^ rd_b_data_i[8*e +: 8];
        default: res_d[8*e +: 8] = rd_a_data_i[8*e +: 8] + rd_b_data_i[8*e +: 8];
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      wr_req_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (wr_req_q && wr_gnt_i) begin
      busy_q   <= 1'b0;
      wr_req_q <= 1'b0;
    end else if (start) begin
      wr_req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q  <= pe.req.op;
      vd_q  <= pe.req.vd;
      vs1_q <= pe.req.vs1;
      vs2_q <= pe.req.vs2;
      hz_q  <= (pe.req.hazard_vs1 | pe.req.hazard_vs2 | pe.req.hazard_vd) & pe.running;
    end else begin
      hz_q <= hz_q & pe.running;
    end
    if (start) res_q <= res_d;
  end

  assign pe.req_ready[PeAlu] = !busy_q;
  assign pe.done[PeAlu]      = wr_req_q && wr_gnt_i;

  assign rd_a_addr_o = vs1_q;
  assign rd_b_addr_o = vs2_q;
  assign wr_req_o    = wr_req_q;
  assign wr_addr_o   = vd_q;
  assign wr_data_o   = res_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) wr_req_o && !wr_gnt_i |=> wr_req_o)
    else $error("ALU dropped its write request before the grant");

endmodule

// File: logic/vec_load_unit.sv
/* Load unit: address check and acknowledge, memory read, register write */
module vec_load_unit import vec_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  pe_req_if.unit         pe,
  mem_port_if.requester  mem,
  output logic           ack_o,
  output logic           err_o,
  output logic           wr_req_o,
  output vreg_t          wr_addr_o,
  output vdata_t         wr_data_o,
  input  logic           wr_gnt_i
);

  typedef enum logic [1:0] {IDLE, CHECK, FETCH, WRITE} state_e;

  state_e    state_q;
  logic      ack_q, err_q, take, hz_clear, addr_bad;
  vreg_t     vd_q;
  addr_t     addr_q;
  vid_mask_t hz_q;
  vdata_t    data_q;

  assign take     = pe.req_valid && (target_pe(pe.req.op) == PeLoad);
  assign hz_clear = !(|(hz_q & pe.running));
  assign addr_bad = (addr_q >= addr_t'(MemWords));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        IDLE:  if (take) state_q <= CHECK;
        CHECK: if (hz_clear) begin
          ack_q   <= 1'b1;
          err_q   <= addr_bad;
          state_q <= addr_bad ? IDLE : FETCH;
        end
        FETCH: if (mem.gnt) state_q <= WRITE;
        WRITE: if (wr_gnt_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      vd_q   <= pe.req.vd;
      addr_q <= pe.req.addr;
      hz_q   <= (pe.req.hazard_vs1 | pe.req.hazard_vs2 | pe.req.hazard_vd) & pe.running;
    end else begin
      hz_q <= hz_q & pe.running;
    end
    if (mem.gnt) data_q <= mem.rdata;
  end

  assign mem.req   = (state_q == FETCH);
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q;
  assign mem.wdata = '0;

  assign ack_o = ack_q;
  assign err_o = err_q;

  assign wr_req_o  = (state_q == WRITE);
  assign wr_addr_o = vd_q;
  assign wr_data_o = data_q;

  assign pe.req_ready[PeLoad] = (state_q == IDLE);
  // A rejected address completes with its acknowledge
  assign pe.done[PeLoad] = (wr_req_o && wr_gnt_i) || (ack_q && err_q);

endmodule

// File: logic/vec_store_unit.sv
/* Store unit: address check and acknowledge, then register to memory */
module vec_store_unit import vec_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  pe_req_if.unit         pe,
  mem_port_if.requester  mem,
  output logic           ack_o,
  output logic           err_o,
  output vreg_t          rd_addr_o,
  input  vdata_t         rd_data_i
);

  typedef enum logic [1:0] {IDLE, CHECK, SEND} state_e;

  state_e    state_q;
  logic      ack_q, err_q, take, hz_clear, addr_bad;
  vreg_t     vs1_q;
  addr_t     addr_q;
  vid_mask_t hz_q;

  assign take     = pe.req_valid && (target_pe(pe.req.op) == PeStore);
  assign hz_clear = !(|(hz_q & pe.running));
  assign addr_bad = (addr_q >= addr_t'(MemWords));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        IDLE:  if (take) state_q <= CHECK;
        CHECK: if (hz_clear) begin
          ack_q   <= 1'b1;
          err_q   <= addr_bad;
          state_q <= addr_bad ? IDLE : SEND;
        end
        SEND:  if (mem.gnt) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      vs1_q  <= pe.req.vs1;
      addr_q <= pe.req.addr;
      hz_q   <= (pe.req.hazard_vs1 | pe.req.hazard_vs2 | pe.req.hazard_vd) & pe.running;
    end else begin
      hz_q <= hz_q & pe.running;
    end
  end

  // Source register is protected by the hazard rules until done
  assign rd_addr_o = vs1_q;
  assign mem.req   = (state_q == SEND);
  assign mem.we    = 1'b1;
  assign mem.addr  = addr_q;
  assign mem.wdata = rd_data_i;

  assign ack_o = ack_q;
  assign err_o = err_q;

  assign pe.req_ready[PeStore] = (state_q == IDLE);
  assign pe.done[PeStore]      = (mem.req && mem.gnt) || (ack_q && err_q);

endmodule

// File: logic/vec_regfile.sv
/* Eight-entry vector register file with three read ports and one
   write port shared by the ALU and the load unit */
module vec_regfile import vec_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  vreg_t  rd_a_addr_i,
  output vdata_t rd_a_data_o,
  input  vreg_t  rd_b_addr_i,
  output vdata_t rd_b_data_o,
  input  vreg_t  rd_c_addr_i,
  output vdata_t rd_c_data_o,
  input  logic   alu_wr_req_i,
  input  vreg_t  alu_wr_addr_i,
  input  vdata_t alu_wr_data_i,
  output logic   alu_wr_gnt_o,
  input  logic   ld_wr_req_i,
  input  vreg_t  ld_wr_addr_i,
  input  vdata_t ld_wr_data_i,
  output logic   ld_wr_gnt_o
);

  vdata_t [NrVRegs-1:0] regs_q;

  assign rd_a_data_o = regs_q[rd_a_addr_i];
  assign rd_b_data_o = regs_q[rd_b_addr_i];
  assign rd_c_data_o = regs_q[rd_c_addr_i];

  // Fixed priority, the ALU wins
  assign alu_wr_gnt_o = alu_wr_req_i;
  assign ld_wr_gnt_o  = ld_wr_req_i && !alu_wr_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (alu_wr_gnt_o) begin
      regs_q[alu_wr_addr_i] <= alu_wr_data_i;
    end else if (ld_wr_gnt_o) begin
      regs_q[ld_wr_addr_i] <= ld_wr_data_i;
    end
  end

endmodule

// File: logic/mem_arbiter.sv
/* Round-robin arbiter of the load and store ports onto the memory bus */
module mem_arbiter import vec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  mem_port_if.arbiter ld,
  mem_port_if.arbiter st,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output vdata_t     mem_wdata_o,
  input  logic       mem_gnt_i,
  input  vdata_t     mem_rdata_i
);

  logic held_q, held_st_q, last_st_q, sel_st;

  // Keep the owner while the bus stalls, else the last winner yields
  always_comb begin
    if (held_q) sel_st = held_st_q;
    else sel_st = st.req && (!ld.req || !last_st_q);
  end

  assign mem_req_o   = ld.req || st.req;
  assign mem_we_o    = sel_st ? st.we : ld.we;
  assign mem_addr_o  = sel_st ? st.addr : ld.addr;
  assign mem_wdata_o = sel_st ? st.wdata : ld.wdata;

  assign ld.gnt   = mem_gnt_i && ld.req && !sel_st;
  assign st.gnt   = mem_gnt_i && sel_st;
  assign ld.rdata = mem_rdata_i;
  assign st.rdata = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q    <= 1'b0;
      held_st_q <= 1'b0;
      last_st_q <= 1'b0;
    end else if (mem_req_o) begin
      held_q    <= !mem_gnt_i;
      held_st_q <= sel_st;
      if (mem_gnt_i) last_st_q <= sel_st;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   mem_req_o && !mem_gnt_i |=> sel_st == $past(sel_st))
    else $error("arbiter switched ports during a stalled transfer");

endmodule

// File: logic/vec_core.sv
/* Top level of the vector issue subsystem: sequencer, ALU, load and
   store units, register file and memory arbiter */
module vec_core import vec_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  vec_op_e req_op_i,
  input  vreg_t   req_vd_i,
  input  vreg_t   req_vs1_i,
  input  vreg_t   req_vs2_i,
  input  addr_t   req_addr_i,
  output logic    resp_valid_o,
  output logic    resp_error_o,
  output logic    idle_o,
  output logic    mem_req_o,
  output logic    mem_we_o,
  output addr_t   mem_addr_o,
  output vdata_t  mem_wdata_o,
  input  logic    mem_gnt_i,
  input  vdata_t  mem_rdata_i
);

  pe_req_if   pe_if ();
  mem_port_if ld_mem_if ();
  mem_port_if st_mem_if ();

  logic   ld_ack, ld_err, st_ack, st_err;
  vreg_t  alu_rd_a_addr, alu_rd_b_addr, st_rd_addr;
  vdata_t alu_rd_a_data, alu_rd_b_data, st_rd_data;
  logic   alu_wr_req, alu_wr_gnt, ld_wr_req, ld_wr_gnt;
  vreg_t  alu_wr_addr, ld_wr_addr;
  vdata_t alu_wr_data, ld_wr_data;

  //////////////////////////////
  // Issue
  //////////////////////////////

  vec_sequencer vec_sequencer_inst (
    .clk_i, .rst_ni, .req_valid_i, .req_ready_o, .req_op_i, .req_vd_i, .req_vs1_i,
    .req_vs2_i, .req_addr_i, .resp_valid_o, .resp_error_o, .idle_o,
    .pe       (pe_if),
    .ld_ack_i (ld_ack),
    .ld_err_i (ld_err),
    .st_ack_i (st_ack),
    .st_err_i (st_err)
  );

  //////////////////////////////
  // Processing elements
  //////////////////////////////

  vec_alu_unit vec_alu_unit_inst (
    .clk_i, .rst_ni,
    .pe          (pe_if),
    .rd_a_addr_o (alu_rd_a_addr),
    .rd_b_addr_o (alu_rd_b_addr),
    .rd_a_data_i (alu_rd_a_data),
    .rd_b_data_i (alu_rd_b_data),
    .wr_req_o    (alu_wr_req),
    .wr_addr_o   (alu_wr_addr),
    .wr_data_o   (alu_wr_data),
    .wr_gnt_i    (alu_wr_gnt)
  );

  vec_load_unit vec_load_unit_inst (
    .clk_i, .rst_ni,
    .pe        (pe_if),
    .mem       (ld_mem_if),
    .ack_o     (ld_ack),
    .err_o     (ld_err),
    .wr_req_o  (ld_wr_req),
    .wr_addr_o (ld_wr_addr),
    .wr_data_o (ld_wr_data),
    .wr_gnt_i  (ld_wr_gnt)
  );

  vec_store_unit vec_store_unit_inst (
    .clk_i, .rst_ni,
    .pe        (pe_if),
    .mem       (st_mem_if),
    .ack_o     (st_ack),
    .err_o     (st_err),
    .rd_addr_o (st_rd_addr),
    .rd_data_i (st_rd_data)
  );

  vec_regfile vec_regfile_inst (
    .clk_i, .rst_ni,
    .rd_a_addr_i   (alu_rd_a_addr),
    .rd_a_data_o   (alu_rd_a_data),
    .rd_b_addr_i   (alu_rd_b_addr),
    .rd_b_data_o   (alu_rd_b_data),
    .rd_c_addr_i   (st_rd_addr),
    .rd_c_data_o   (st_rd_data),
    .alu_wr_req_i  (alu_wr_req),
    .alu_wr_addr_i (alu_wr_addr),
    .alu_wr_data_i (alu_wr_data),
    .alu_wr_gnt_o  (alu_wr_gnt),
    .ld_wr_req_i   (ld_wr_req),
    .ld_wr_addr_i  (ld_wr_addr),
    .ld_wr_data_i  (ld_wr_data),
    .ld_wr_gnt_o   (ld_wr_gnt)
  );

  mem_arbiter mem_arbiter_inst (
    .clk_i, .rst_ni,
    .ld (ld_mem_if),
    .st (st_mem_if),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_gnt_i, .mem_rdata_i
  );

endmodule

// File: test/tb_vec_core.sv
/* Testbench for vec_core: clock, reset, LFSR program, memory bus model,
   in-order reference model, response and bus checks, timeout */
module tb_vec_core import vec_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumInsn       = 300;
  localparam int TimeoutCycles = NumInsn * 30 + 200;
  localparam int ClkPeriod     = 40;
  localparam int DriveDelay    = 2;
  localparam int NumGntDelays  = 512;

  logic    clk_i, rst_ni;
  logic    req_valid_i, req_ready_o;
  vec_op_e req_op_i;
  vreg_t   req_vd_i, req_vs1_i, req_vs2_i;
  addr_t   req_addr_i;
  logic    resp_valid_o, resp_error_o, idle_o;
  logic    mem_req_o, mem_we_o, mem_gnt_i;
  addr_t   mem_addr_o;
  vdata_t  mem_wdata_o, mem_rdata_i;

  logic [31:0] lfsr_q;
  vdata_t      mem_q [MemWords];
  vdata_t      ref_mem [MemWords];
  vdata_t      ref_regs [NrVRegs];
  vec_op_e     prog_op [NumInsn];
  vreg_t       prog_vd [NumInsn];
  vreg_t       prog_vs1 [NumInsn];
  vreg_t       prog_vs2 [NumInsn];
  addr_t       prog_addr [NumInsn];
  logic [1:0]  prog_gap [NumInsn];
  logic [1:0]  gnt_delay [NumGntDelays];
  logic        exp_err_q [$];
  addr_t       exp_wr_addr_q [$];
  vdata_t      exp_wr_data_q [$];
  logic        resp_pending;
  int          errors, resp_count, wr_count;

  vec_core vec_core_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // Random source and model
  //////////////////////////////

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Four independent 8-bit lanes, carries do not cross lanes
  function automatic vdata_t alu_ref(input vec_op_e op, input vdata_t a, input vdata_t b);
    vdata_t     r;
    logic [7:0] x, y;
    r = '0;
    for (int e = 0; e < 4; e++) begin
      x = a[8*e +: 8];
      y = b[8*e +: 8];
      case (op)
        VADD:    r[8*e +: 8] = x + y;
        VSUB:    r[8*e +: 8] = x - y;
        VAND:    r[8*e +: 8] = x & y;
        default: r[8*e +: 8] = x ^ y;
      endcase
    end
    return r;
  endfunction

  task automatic make_program();
    logic [31:0] v;
    for (int w = 0; w < MemWords; w++) begin
      draw_bits(32, v);
      mem_q[w]   = v;
      ref_mem[w] = v;
    end
    for (int i = 0; i < NumInsn; i++) begin
      draw_bits(3, v);
      case (v[2:0])
        3'd0:         prog_op[i] = VADD;
        3'd1:         prog_op[i] = VSUB;
        3'd2:         prog_op[i] = VAND;
        3'd3:         prog_op[i] = VXOR;
        3'd4, 3'd5:   prog_op[i] = VLE;
        default:      prog_op[i] = VSE;
      endcase
      draw_bits(3, v);
      prog_vd[i] = vreg_t'(v);
      draw_bits(3, v);
      prog_vs1[i] = vreg_t'(v);
      draw_bits(3, v);
      prog_vs2[i] = vreg_t'(v);
      // One address in eight lands outside memory
      draw_bits(3, v);
      if (v[2:0] == 3'd0) begin
        draw_bits(8, v);
        prog_addr[i] = addr_t'(v) | 8'h40;
      end else begin
        draw_bits(6, v);
        prog_addr[i] = addr_t'(v);
      end
      draw_bits(2, v);
      prog_gap[i] = v[1:0];
    end
    for (int g = 0; g < NumGntDelays; g++) begin
      draw_bits(2, v);
      gnt_delay[g] = v[1:0];
    end
  endtask

  // Sequential semantics in program order
  task automatic model_insn(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                            input vreg_t vs2, input addr_t addr);
    case (op)
      VLE: if (addr < MemWords) ref_regs[vd] = ref_mem[addr[5:0]];
      VSE: if (addr < MemWords) begin
        ref_mem[addr[5:0]] = ref_regs[vs1];
        exp_wr_addr_q.push_back(addr);
        exp_wr_data_q.push_back(ref_regs[vs1]);
      end
      default: ref_regs[vd] = alu_ref(op, ref_regs[vs1], ref_regs[vs2]);
    endcase
    if (is_mem(op)) begin
      exp_err_q.push_back(addr >= MemWords);
      resp_pending = 1'b1;
    end
  endtask

  //////////////////////////////
  // Driver
  //////////////////////////////

  task automatic issue(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                       input vreg_t vs2, input addr_t addr);
    req_op_i    = op;
    req_vd_i    = vd;
    req_vs1_i   = vs1;
    req_vs2_i   = vs2;
    req_addr_i  = addr;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DriveDelay;
    req_valid_i = 1'b0;
    model_insn(op, vd, vs1, vs2, addr);
    if (idle_o !== 1'b0) begin
      errors++;
      $display("** Error at %0t: idle_o = %0b, expected 0", $time, idle_o);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (!idle_o || exp_err_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Memory bus model
  //////////////////////////////

  task automatic serve_bus();
    addr_t  exp_addr;
    vdata_t exp_data;
    if (mem_addr_o >= MemWords) begin
      errors++;
      $display("Bus access at %0t to address %0d outside memory", $time, mem_addr_o);
    end else if (mem_we_o) begin
      wr_count++;
      if (exp_wr_addr_q.size() == 0) begin
        errors++;
        $display("Bus write at %0t with no store expected", $time);
      end else begin
        exp_addr = exp_wr_addr_q.pop_front();
        exp_data = exp_wr_data_q.pop_front();
        if (mem_addr_o !== exp_addr) begin
          errors++;
          $display("** Error at %0t: mem_addr_o = %0d, expected %0d", $time, mem_addr_o,
                   exp_addr);
        end
        if (mem_wdata_o !== exp_data) begin
          errors++;
          $display("** Error at %0t: mem_wdata_o = %h, expected %h", $time, mem_wdata_o,
                   exp_data);
        end
      end
      mem_q[mem_addr_o[5:0]] = mem_wdata_o;
    end else begin
      mem_rdata_i = mem_q[mem_addr_o[5:0]];
    end
  endtask

  initial begin : bus_model
    int         wait_left;
    logic [8:0] gnt_idx;
    wait_left = -1;
    gnt_idx   = '0;
    forever begin
      @(posedge clk_i);
      #DriveDelay;
      mem_gnt_i = 1'b0;
      if (rst_ni && mem_req_o) begin
        // New delay per transfer, 0 to 3 cycles
        if (wait_left < 0) begin
          wait_left = int'(gnt_delay[gnt_idx]);
          gnt_idx++;
        end
        if (wait_left == 0) begin
          wait_left = -1;
          mem_gnt_i = 1'b1;
          serve_bus();
        end else begin
          wait_left--;
        end
      end
    end
  end

  //////////////////////////////
  // Response monitor
  //////////////////////////////

  always @(negedge clk_i) begin : resp_monitor
    logic exp_err;
    if (rst_ni && resp_valid_o) begin
      resp_count++;
      if (exp_err_q.size() == 0) begin
        errors++;
        $display("Response at %0t with no memory instruction outstanding", $time);
      end else begin
        exp_err = exp_err_q.pop_front();
        check_bit("resp_error_o", resp_error_o, exp_err);
        resp_pending = 1'b0;
      end
    end
    if (rst_ni && req_valid_i && req_ready_o && resp_pending) begin
      errors++;
      $display("Request accepted at %0t before the memory response", $time);
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped making progress", TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    errors       = 0;
    resp_count   = 0;
    wr_count     = 0;
    resp_pending = 1'b0;
    lfsr_q       = 32'h13d1;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = VADD;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_addr_i   = '0;
    mem_gnt_i    = 1'b0;
    mem_rdata_i  = '0;
    for (int r = 0; r < NrVRegs; r++) ref_regs[r] = '0;
    make_program();

    repeat (5) @(posedge clk_i);
    #DriveDelay;
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_bit("mem_req_o", mem_req_o, 1'b0);
    check_bit("idle_o", idle_o, 1'b1);
    rst_ni = 1'b1;

    // Quiet cycles before the first request
    repeat (3) begin
      @(negedge clk_i);
      check_bit("idle_o", idle_o, 1'b1);
      check_bit("req_ready_o", req_ready_o, 1'b1);
      check_bit("resp_valid_o", resp_valid_o, 1'b0);
      check_bit("mem_req_o", mem_req_o, 1'b0);
    end
    @(posedge clk_i);
    #DriveDelay;

    for (int i = 0; i < NumInsn; i++) begin
      issue(prog_op[i], prog_vd[i], prog_vs1[i], prog_vs2[i], prog_addr[i]);
      repeat (prog_gap[i]) begin
        @(posedge clk_i);
        #DriveDelay;
      end
    end
    wait_idle();

    // Drain every register to memory
    for (int r = 0; r < NrVRegs; r++) begin
      issue(VSE, '0, vreg_t'(r), '0, addr_t'(r));
    end
    wait_idle();

    for (int w = 0; w < MemWords; w++) begin
      if (mem_q[w] !== ref_mem[w]) begin
        errors++;
        $display("** Error at %0t: mem[%0d] = %h, expected %h", $time, w, mem_q[w], ref_mem[w]);
      end
    end
    if (exp_wr_addr_q.size() != 0 || resp_pending) begin
      errors++;
      $display("Stores or responses still missing after the run drained");
    end

    $display("Run done: %0d instructions, %0d responses, %0d bus writes, %0d errors",
             NumInsn + NrVRegs, resp_count, wr_count, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: list.f
common/vec_pkg.sv
common/pe_req_if.sv
common/mem_port_if.sv
sequencer/vec_sequencer.sv
logic/vec_alu_unit.sv
logic/vec_load_unit.sv
logic/vec_store_unit.sv
logic/vec_regfile.sv
logic/mem_arbiter.sv
logic/vec_core.sv
test/tb_vec_core.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_vec_core
FILELIST   := list.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
PASS_STR   := Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)
